// ==== decode_config.svh ====
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Data and address width of the core
`define DECODE_XLEN 32

// Register-file address width, 32 architectural registers
`define DECODE_REG_AW 5

// Extra cycles on top of the summed test lengths before the
// testbench gives up
`define DECODE_TIMEOUT_MARGIN 200

`endif

// ==== riscv_isa_pkg.sv ====
`include "decode_config.svh"

package riscv_isa_pkg;

    // Major opcodes, bits [6:0] of every 32-bit instruction
    typedef enum logic [6:0] {
        OPC_OP     = 7'b011_0011,
        OPC_OP_IMM = 7'b001_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_AUIPC  = 7'b001_0111,
        OPC_JAL    = 7'b110_1111,
        OPC_JALR   = 7'b110_0111,
        OPC_BRANCH = 7'b110_0011,
        OPC_LOAD   = 7'b000_0011,
        OPC_STORE  = 7'b010_0011,
        // Not supported by this core, listed so they can be named
        OPC_SYSTEM = 7'b111_0011,
        OPC_FENCE  = 7'b000_1111,
        OPC_AMO    = 7'b010_1111
    } opcode_e;

    // R-type field layout, other formats reuse the same bit positions
    typedef struct packed {
        logic [6:0]                funct7;
        logic [`DECODE_REG_AW-1:0] rs2;
        logic [`DECODE_REG_AW-1:0] rs1;
        logic [2:0]                funct3;
        logic [`DECODE_REG_AW-1:0] rd;
        opcode_e                   opcode;
    } instr_fields_t;

    // funct7 values
    localparam logic [6:0] FUNCT7_BASE   = 7'b000_0000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b010_0000;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b000_0001;

    // funct3 codes of the integer ALU group
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SR      = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

endpackage

// ==== decode_pipe_pkg.sv ====
`include "decode_config.svh"

package decode_pipe_pkg;

    // Coarse class, picks the execute-stage unit
    typedef enum logic [2:0] {
        TYPE_ALU,
        TYPE_MULDIV,
        TYPE_JUMP,
        TYPE_BRANCH,
        TYPE_LOAD,
        TYPE_STORE
    } instr_type_e;

    // ALU and multiplier/divider operation
    // MUL..REMU follow funct3 order so decode can add an offset
    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_XOR, ALU_OR, ALU_AND,
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
        ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
    } alu_sel_e;

    // First ALU operand
    typedef enum logic [0:0] {
        IN0_RS1,
        IN0_PC
    } in0_sel_e;

    // Second ALU operand, one entry per immediate format
    typedef enum logic [2:0] {
        IN1_RS2,
        IN1_SIMM12,
        IN1_IMM_STORE,
        IN1_IMM_BRANCH,
        IN1_IMM_JAL,
        IN1_IMM_U
    } in1_sel_e;

    // Source of the value written back to rd
    typedef enum logic [1:0] {
        RD_ALU,
        RD_MULDIV,
        RD_MEMORY,
        RD_LUI
    } rd_sel_e;

    // Control bundle handed to execute, 15 bits
    typedef struct packed {
        instr_type_e instr_type;
        alu_sel_e    alu_sel;
        in0_sel_e    in0_sel;
        in1_sel_e    in1_sel;
        rd_sel_e     rd_sel;
        logic        illegal;
    } decode_ctrl_t;

    // Commands from execute toward the front end
    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_KILL,
        CMD_BRANCH
    } pipe_cmd_e;

    // Fetch to decode payload
    typedef struct packed {
        logic [`DECODE_XLEN-1:0] instr;
        logic [`DECODE_XLEN-1:0] pc;
    } f2d_t;

    // Decode to execute payload
    typedef struct packed {
        logic [`DECODE_XLEN-1:0] instr;
        logic [`DECODE_XLEN-1:0] pc;
        decode_ctrl_t            ctrl;
    } d2e_t;

endpackage

// ==== decode_classify.sv ====
`timescale 1ns/1ps

module decode_classify
    import riscv_isa_pkg::*;
    import decode_pipe_pkg::*;
(
    input  instr_fields_t instr,
    output decode_ctrl_t  ctrl,
    output logic          rs1_used,
    output logic          rs2_used
);

    // Shared OP / OP_IMM mapping, alt selects SUB or SRA
    function automatic alu_sel_e alu_base(input logic [2:0] funct3, input logic alt);
        case (funct3)
            FUNCT3_ADD_SUB: alu_base = alt ? ALU_SUB : ALU_ADD;
            FUNCT3_SLL:     alu_base = ALU_SLL;
            FUNCT3_SLT:     alu_base = ALU_SLT;
            FUNCT3_SLTU:    alu_base = ALU_SLTU;
            FUNCT3_XOR:     alu_base = ALU_XOR;
            FUNCT3_SR:      alu_base = alt ? ALU_SRA : ALU_SRL;
            FUNCT3_OR:      alu_base = ALU_OR;
            default:        alu_base = ALU_AND;
        endcase
    endfunction

    logic f7_base;
    logic f7_alt;
    logic f7_muldiv;
    logic illegal;

    assign f7_base   = (instr.funct7 == FUNCT7_BASE);
    assign f7_alt    = (instr.funct7 == FUNCT7_ALT);
    assign f7_muldiv = (instr.funct7 == FUNCT7_MULDIV);

    always_comb begin
        // Defaults double as the illegal-instruction bundle
        ctrl.instr_type = TYPE_ALU;
        ctrl.alu_sel    = ALU_ADD;
        ctrl.in0_sel    = IN0_RS1;
        ctrl.in1_sel    = IN1_RS2;
        ctrl.rd_sel     = RD_ALU;
        ctrl.illegal    = 1'b0;
        rs1_used        = 1'b0;
        rs2_used        = 1'b0;
        illegal         = 1'b0;

        case (instr.opcode)
            OPC_OP: begin
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                if (f7_muldiv) begin
                    ctrl.instr_type = TYPE_MULDIV;
                    ctrl.alu_sel    = alu_sel_e'(ALU_MUL + instr.funct3);
                    ctrl.rd_sel     = RD_MULDIV;
                end else if (f7_base) begin
                    ctrl.alu_sel = alu_base(instr.funct3, 1'b0);
                end else if (f7_alt && (instr.funct3 == FUNCT3_ADD_SUB ||
                                        instr.funct3 == FUNCT3_SR)) begin
                    ctrl.alu_sel = alu_base(instr.funct3, 1'b1);
                end else begin
                    illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                rs1_used     = 1'b1;
                ctrl.in1_sel = IN1_SIMM12;
                // funct7 is immediate data except on shifts
                ctrl.alu_sel = alu_base(instr.funct3, f7_alt && instr.funct3 == FUNCT3_SR);
                if (instr.funct3 == FUNCT3_SLL && !f7_base)
                    illegal = 1'b1;
                if (instr.funct3 == FUNCT3_SR && !f7_base && !f7_alt)
                    illegal = 1'b1;
            end
            OPC_JAL: begin
                ctrl.instr_type = TYPE_JUMP;
                ctrl.in0_sel    = IN0_PC;
                ctrl.in1_sel    = IN1_IMM_JAL;
            end
            OPC_JALR: begin
                rs1_used        = 1'b1;
                ctrl.instr_type = TYPE_JUMP;
                ctrl.in1_sel    = IN1_SIMM12;
                illegal         = (instr.funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                rs1_used        = 1'b1;
                rs2_used        = 1'b1;
                ctrl.instr_type = TYPE_BRANCH;
                ctrl.in0_sel    = IN0_PC;
                ctrl.in1_sel    = IN1_IMM_BRANCH;
            end
            OPC_LOAD: begin
                rs1_used        = 1'b1;
                ctrl.instr_type = TYPE_LOAD;
                ctrl.in1_sel    = IN1_SIMM12;
                ctrl.rd_sel     = RD_MEMORY;
            end
            OPC_STORE: begin
                rs1_used        = 1'b1;
                rs2_used        = 1'b1;
                ctrl.instr_type = TYPE_STORE;
                ctrl.in1_sel    = IN1_IMM_STORE;
                // Only SB, SH and SW exist on RV32
                illegal         = instr.funct3[2];
            end
            // Immediate comes straight from the instruction word
            OPC_LUI: ctrl.rd_sel = RD_LUI;
            OPC_AUIPC: begin
                ctrl.in0_sel = IN0_PC;
                ctrl.in1_sel = IN1_IMM_U;
            end
            // SYSTEM, FENCE, AMO and unknown opcodes
            default: illegal = 1'b1;
        endcase

        // Illegal words read nothing and carry the default bundle
        if (illegal) begin
            ctrl.instr_type = TYPE_ALU;
            ctrl.alu_sel    = ALU_ADD;
            ctrl.in0_sel    = IN0_RS1;
            ctrl.in1_sel    = IN1_RS2;
            ctrl.rd_sel     = RD_ALU;
            ctrl.illegal    = 1'b1;
            rs1_used        = 1'b0;
            rs2_used        = 1'b0;
        end
    end

endmodule

// ==== decode_hazard.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module decode_hazard (
    input  logic [`DECODE_REG_AW-1:0] rs1_addr,
    input  logic [`DECODE_REG_AW-1:0] rs2_addr,
    input  logic                      rs1_used,
    input  logic                      rs2_used,
    input  logic                      e2d_rd_write,
    input  logic [`DECODE_REG_AW-1:0] e2d_rd_waddr,
    output logic                      stall
);

    logic rs1_match;
    logic rs2_match;
    logic rs1_stale;
    logic rs2_stale;

    // Address compares against execute's pending destination
    assign rs1_match = (rs1_addr == e2d_rd_waddr);
    assign rs2_match = (rs2_addr == e2d_rd_waddr);

    // Only sources the instruction actually reads count
    // x0 is compared like any other register
    assign rs1_stale = rs1_used && rs1_match && e2d_rd_write;
    assign rs2_stale = rs2_used && rs2_match && e2d_rd_write;

    // Hold the instruction in fetch until the write lands
    assign stall = rs1_stale || rs2_stale;

endmodule

// ==== decode_stage_reg.sv ====
`timescale 1ns/1ps

module decode_stage_reg
    import decode_pipe_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         f2d_valid,
    input  f2d_t         f2d,
    input  decode_ctrl_t ctrl,
    input  logic         rs1_used,
    input  logic         rs2_used,
    input  logic         stall,
    output logic         d2f_ready,
    input  logic         e2d_ready,
    input  pipe_cmd_e    e2d_cmd,
    output logic         d2e_valid,
    output d2e_t         d2e,
    output logic         rs1_read,
    output logic         rs2_read
);

    logic out_free;
    logic cmd_active;
    logic f2d_fire;

    // Output slot empty or being drained this cycle
    assign out_free = !d2e_valid || e2d_ready;

    // Kill or branch from execute flushes decode
    assign cmd_active = (e2d_cmd != CMD_NONE);

    assign d2f_ready = out_free && !stall && !cmd_active;
    assign f2d_fire  = f2d_valid && d2f_ready;

    // Register file reads only on an accepted instruction
    assign rs1_read = f2d_fire && rs1_used;
    assign rs2_read = f2d_fire && rs2_used;

    // Occupancy of the output register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            d2e_valid <= 1'b0;
        end else if (cmd_active) begin
            d2e_valid <= 1'b0;
        end else if (f2d_fire) begin
            d2e_valid <= 1'b1;
        end else if (e2d_ready) begin
            // Drained with nothing behind it
            d2e_valid <= 1'b0;
        end
    end

    // Payload loads only on a transfer, holds otherwise
    always_ff @(posedge clk) begin
        if (f2d_fire) begin
            d2e.instr <= f2d.instr;
            d2e.pc    <= f2d.pc;
            d2e.ctrl  <= ctrl;
        end
    end

endmodule

// ==== decode_top.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module decode_top
    import riscv_isa_pkg::*;
    import decode_pipe_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    // Fetch side
    input  logic                      f2d_valid,
    input  f2d_t                      f2d,
    output logic                      d2f_ready,
    output pipe_cmd_e                 d2f_cmd,
    output logic [`DECODE_XLEN-1:0]   d2f_jump_target,
    // Execute side
    output logic                      d2e_valid,
    output d2e_t                      d2e,
    input  logic                      e2d_ready,
    input  pipe_cmd_e                 e2d_cmd,
    input  logic [`DECODE_XLEN-1:0]   e2d_jump_target,
    input  logic                      e2d_rd_write,
    input  logic [`DECODE_REG_AW-1:0] e2d_rd_waddr,
    // Register file read port
    output logic                      rs1_read,
    output logic [`DECODE_REG_AW-1:0] rs1_addr,
    output logic                      rs2_read,
    output logic [`DECODE_REG_AW-1:0] rs2_addr
);

    instr_fields_t fields;
    decode_ctrl_t  ctrl;
    logic          rs1_used;
    logic          rs2_used;
    logic          stall;

    assign fields   = instr_fields_t'(f2d.instr);
    assign rs1_addr = fields.rs1;
    assign rs2_addr = fields.rs2;

    // Execute commands reach fetch in the same cycle
    assign d2f_cmd         = e2d_cmd;
    assign d2f_jump_target = e2d_jump_target;

    decode_classify classify_i (
        .instr    (fields),
        .ctrl     (ctrl),
        .rs1_used (rs1_used),
        .rs2_used (rs2_used)
    );

    decode_hazard hazard_i (
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_used     (rs1_used),
        .rs2_used     (rs2_used),
        .e2d_rd_write (e2d_rd_write),
        .e2d_rd_waddr (e2d_rd_waddr),
        .stall        (stall)
    );

    decode_stage_reg stage_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .f2d_valid (f2d_valid),
        .f2d       (f2d),
        .ctrl      (ctrl),
        .rs1_used  (rs1_used),
        .rs2_used  (rs2_used),
        .stall     (stall),
        .d2f_ready (d2f_ready),
        .e2d_ready (e2d_ready),
        .e2d_cmd   (e2d_cmd),
        .d2e_valid (d2e_valid),
        .d2e       (d2e),
        .rs1_read  (rs1_read),
        .rs2_read  (rs2_read)
    );

endmodule

// ==== decode_props.sv ====
`timescale 1ns/1ps

module decode_props
    import decode_pipe_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic d2e_valid,
    input d2e_t d2e,
    input logic e2d_ready,
    input logic d2f_ready,
    input logic rs1_read,
    input logic rs2_read
);

    // Number of property violations so far
    int fail_count = 0;

    // Output register empty while held in reset
    assert property (@(posedge clk) !arst_n |-> !d2e_valid)
        else begin
            fail_count++;
            $error("d2e_valid high during reset");
        end

    // Payload frozen while execute is not taking it
    assert property (@(posedge clk) disable iff (!arst_n)
                     d2e_valid && !e2d_ready |=> $stable(d2e))
        else begin
            fail_count++;
            $error("d2e changed under back-pressure");
        end

    // No register read without an accepted instruction
    assert property (@(posedge clk) disable iff (!arst_n)
                     !d2f_ready |-> !rs1_read && !rs2_read)
        else begin
            fail_count++;
            $error("register read strobe while d2f_ready is low");
        end

endmodule

bind decode_top decode_props props_i (.*);

// ==== tb_decode_top.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module tb_decode_top
    import riscv_isa_pkg::*;
    import decode_pipe_pkg::*;
();

    // Decodes in tests 1 to 3, one cycle each when nothing stalls
    localparam int DECODE_COUNT  = 19 + 8 + 13;
    // Back-pressure 6, hazard 5, two commands of 2 each
    localparam int DIRECTED_CYCS = 6 + 5 + 2 * 2;
    localparam int CYCLE_LIMIT   = 8 + DECODE_COUNT + DIRECTED_CYCS + `DECODE_TIMEOUT_MARGIN;

    logic                      clk;
    logic                      arst_n;
    logic                      f2d_valid;
    f2d_t                      f2d;
    logic                      d2f_ready;
    pipe_cmd_e                 d2f_cmd;
    logic [`DECODE_XLEN-1:0]   d2f_jump_target;
    logic                      d2e_valid;
    d2e_t                      d2e;
    logic                      e2d_ready;
    pipe_cmd_e                 e2d_cmd;
    logic [`DECODE_XLEN-1:0]   e2d_jump_target;
    logic                      e2d_rd_write;
    logic [`DECODE_REG_AW-1:0] e2d_rd_waddr;
    logic                      rs1_read;
    logic [`DECODE_REG_AW-1:0] rs1_addr;
    logic                      rs2_read;
    logic [`DECODE_REG_AW-1:0] rs2_addr;

    logic [31:0] lcg_state = 32'h65ca3c5d;
    string       test_name;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          total_errors;
    int          cycles = 0;

    decode_top dut_i (.*);

    always #10 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = next_random();
        return r[20:16];
    endfunction

    // Builds an instruction word from its fields, rd random
    function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input opcode_e opc);
        instr_fields_t w;
        w.funct7 = f7;
        w.rs2    = rs2;
        w.rs1    = rs1;
        w.funct3 = f3;
        w.rd     = rand_reg();
        w.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] random_regs(input logic [6:0] f7, input logic [2:0] f3,
            input opcode_e opc);
        return encode(f7, rand_reg(), rand_reg(), f3, opc);
    endfunction

    function automatic decode_ctrl_t pack_ctrl(input instr_type_e t, input alu_sel_e a,
            input in0_sel_e i0, input in1_sel_e i1, input rd_sel_e rd, input logic ill);
        return '{t, a, i0, i1, rd, ill};
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s", test_name);
        end else begin
            $display("FAIL %s with %0d failed checks", test_name, test_errors);
            tests_failed++;
            total_errors += test_errors;
        end
    endtask

    // Presents one word, returns once decode took it
    // Entered and left 2 ns after a rising edge
    task automatic send(input logic [31:0] instr, input logic [31:0] pc,
            output logic r1, output logic r2);
        f2d_valid = 1'b1;
        f2d.instr = instr;
        f2d.pc    = pc;
        #1;
        while (!d2f_ready) begin
            @(posedge clk);
            #3;
        end
        check("rs1_addr", instr[19:15], rs1_addr);
        check("rs2_addr", instr[24:20], rs2_addr);
        // Strobes belong to the transfer cycle
        r1 = rs1_read;
        r2 = rs2_read;
        @(posedge clk);
        #2;
        f2d_valid = 1'b0;
    endtask

    task automatic decode_one(input logic [31:0] instr, input decode_ctrl_t exp,
            input logic use1, input logic use2);
        logic [31:0] pc;
        logic        r1;
        logic        r2;
        pc = next_random() & 32'hffff_fffc;
        send(instr, pc, r1, r2);
        check("d2e_valid", 1'b1, d2e_valid);
        check("d2e.instr", instr, d2e.instr);
        check("d2e.pc", pc, d2e.pc);
        check("d2e.ctrl", exp, d2e.ctrl);
        check("rs1_read", use1, r1);
        check("rs2_read", use2, r2);
    endtask

    task automatic run_op(input logic [6:0] f7, input logic [2:0] f3, input opcode_e opc,
            input alu_sel_e alu);
        logic reg_op;
        reg_op = (opc == OPC_OP);
        decode_one(random_regs(f7, f3, opc), pack_ctrl(TYPE_ALU, alu, IN0_RS1,
                   reg_op ? IN1_RS2 : IN1_SIMM12, RD_ALU, 1'b0), 1'b1, reg_op);
    endtask

    task automatic test_alu();
        logic [6:0] imm_hi;
        start_test("alu decode");
        imm_hi = 7'(next_random());
        run_op(FUNCT7_BASE, FUNCT3_ADD_SUB, OPC_OP, ALU_ADD);
        run_op(FUNCT7_ALT, FUNCT3_ADD_SUB, OPC_OP, ALU_SUB);
        run_op(FUNCT7_BASE, FUNCT3_SLL, OPC_OP, ALU_SLL);
        run_op(FUNCT7_BASE, FUNCT3_SLT, OPC_OP, ALU_SLT);
        run_op(FUNCT7_BASE, FUNCT3_SLTU, OPC_OP, ALU_SLTU);
        run_op(FUNCT7_BASE, FUNCT3_XOR, OPC_OP, ALU_XOR);
        run_op(FUNCT7_BASE, FUNCT3_SR, OPC_OP, ALU_SRL);
        run_op(FUNCT7_ALT, FUNCT3_SR, OPC_OP, ALU_SRA);
        run_op(FUNCT7_BASE, FUNCT3_OR, OPC_OP, ALU_OR);
        run_op(FUNCT7_BASE, FUNCT3_AND, OPC_OP, ALU_AND);
        // Immediate forms, upper bits are plain immediate data
        run_op(imm_hi, FUNCT3_ADD_SUB, OPC_OP_IMM, ALU_ADD);
        run_op(imm_hi, FUNCT3_SLT, OPC_OP_IMM, ALU_SLT);
        run_op(imm_hi, FUNCT3_SLTU, OPC_OP_IMM, ALU_SLTU);
        run_op(imm_hi, FUNCT3_XOR, OPC_OP_IMM, ALU_XOR);
        run_op(imm_hi, FUNCT3_OR, OPC_OP_IMM, ALU_OR);
        run_op(imm_hi, FUNCT3_AND, OPC_OP_IMM, ALU_AND);
        run_op(FUNCT7_BASE, FUNCT3_SLL, OPC_OP_IMM, ALU_SLL);
        run_op(FUNCT7_BASE, FUNCT3_SR, OPC_OP_IMM, ALU_SRL);
        run_op(FUNCT7_ALT, FUNCT3_SR, OPC_OP_IMM, ALU_SRA);
        finish_test();
    endtask

    task automatic test_muldiv();
        alu_sel_e ops[8] = '{ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
                             ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
        start_test("muldiv decode");
        for (int i = 0; i < 8; i++) begin
            decode_one(random_regs(FUNCT7_MULDIV, 3'(i), OPC_OP), pack_ctrl(TYPE_MULDIV,
                       ops[i], IN0_RS1, IN1_RS2, RD_MULDIV, 1'b0), 1'b1, 1'b1);
        end
        finish_test();
    endtask

    task automatic test_other();
        logic [6:0]   h;
        decode_ctrl_t bad;
        start_test("control, memory, upper and illegal decode");
        h   = 7'(next_random());
        bad = pack_ctrl(TYPE_ALU, ALU_ADD, IN0_RS1, IN1_RS2, RD_ALU, 1'b1);
        decode_one(random_regs(h, 3'b011, OPC_JAL),
                   pack_ctrl(TYPE_JUMP, ALU_ADD, IN0_PC, IN1_IMM_JAL, RD_ALU, 1'b0), 0, 0);
        decode_one(random_regs(h, 3'b000, OPC_JALR),
                   pack_ctrl(TYPE_JUMP, ALU_ADD, IN0_RS1, IN1_SIMM12, RD_ALU, 1'b0), 1, 0);
        decode_one(random_regs(h, 3'b001, OPC_BRANCH),
                   pack_ctrl(TYPE_BRANCH, ALU_ADD, IN0_PC, IN1_IMM_BRANCH, RD_ALU, 1'b0), 1, 1);
        decode_one(random_regs(h, 3'b010, OPC_LOAD),
                   pack_ctrl(TYPE_LOAD, ALU_ADD, IN0_RS1, IN1_SIMM12, RD_MEMORY, 1'b0), 1, 0);
        decode_one(random_regs(h, 3'b010, OPC_STORE),
                   pack_ctrl(TYPE_STORE, ALU_ADD, IN0_RS1, IN1_IMM_STORE, RD_ALU, 1'b0), 1, 1);
        decode_one(random_regs(h, 3'b101, OPC_LUI),
                   pack_ctrl(TYPE_ALU, ALU_ADD, IN0_RS1, IN1_RS2, RD_LUI, 1'b0), 0, 0);
        decode_one(random_regs(h, 3'b110, OPC_AUIPC),
                   pack_ctrl(TYPE_ALU, ALU_ADD, IN0_PC, IN1_IMM_U, RD_ALU, 1'b0), 0, 0);
        // Dropped or malformed encodings
        decode_one(random_regs(h, 3'b000, OPC_SYSTEM), bad, 0, 0);
        decode_one(random_regs(h, 3'b001, OPC_FENCE), bad, 0, 0);
        decode_one(random_regs(h, 3'b010, OPC_AMO), bad, 0, 0);
        decode_one(random_regs(7'b000_0010, FUNCT3_ADD_SUB, OPC_OP), bad, 0, 0);
        decode_one(random_regs(h, 3'b001, OPC_JALR), bad, 0, 0);
        decode_one(random_regs(h, 3'b100, OPC_STORE), bad, 0, 0);
        finish_test();
    endtask

    task automatic test_backpressure();
        logic [31:0] a;
        logic        r1;
        logic        r2;
        start_test("back-pressure");
        a = random_regs(FUNCT7_BASE, FUNCT3_XOR, OPC_OP);
        send(a, 32'h200, r1, r2);
        // Execute stops taking words, a stays parked
        e2d_ready = 1'b0;
        // Second word waits behind the full output register
        f2d_valid = 1'b1;
        f2d.instr = random_regs(FUNCT7_BASE, FUNCT3_OR, OPC_OP);
        f2d.pc    = 32'h204;
        repeat (3) begin
            #1;
            check("held d2f_ready", 1'b0, d2f_ready);
            check("held d2e_valid", 1'b1, d2e_valid);
            check("held d2e.instr", a, d2e.instr);
            @(posedge clk);
            #2;
        end
        e2d_ready = 1'b1;
        #1;
        check("drain d2f_ready", 1'b1, d2f_ready);
        @(posedge clk);
        #2;
        f2d_valid = 1'b0;
        check("queued d2e.instr", f2d.instr, d2e.instr);
        check("queued d2e.pc", 32'h204, d2e.pc);
        @(posedge clk);
        #2;
        check("drained d2e_valid", 1'b0, d2e_valid);
        finish_test();
    endtask

    task automatic test_hazard();
        logic [4:0] r;
        start_test("hazard stall");
        r            = rand_reg();
        e2d_rd_write = 1'b1;
        e2d_rd_waddr = r;
        f2d_valid    = 1'b1;
        f2d.instr    = encode(FUNCT7_BASE, r ^ 5'd1, r, FUNCT3_ADD_SUB, OPC_OP);
        f2d.pc       = 32'h300;
        repeat (3) begin
            #1;
            check("stalled d2f_ready", 1'b0, d2f_ready);
            check("stalled rs1_read", 1'b0, rs1_read);
            check("stalled rs2_read", 1'b0, rs2_read);
            @(posedge clk);
            #2;
        end
        // Pending write done
        e2d_rd_write = 1'b0;
        #1;
        check("released d2f_ready", 1'b1, d2f_ready);
        check("released rs1_read", 1'b1, rs1_read);
        check("released rs2_read", 1'b1, rs2_read);
        @(posedge clk);
        #2;
        check("released d2e.instr", f2d.instr, d2e.instr);
        // rs2 slot of OP_IMM holds immediate bits, no stall
        e2d_rd_write = 1'b1;
        f2d.instr    = encode(7'h15, r, r ^ 5'd1, FUNCT3_ADD_SUB, OPC_OP_IMM);
        #1;
        check("unused rs2 d2f_ready", 1'b1, d2f_ready);
        check("unused rs2 rs2_read", 1'b0, rs2_read);
        @(posedge clk);
        #2;
        f2d_valid    = 1'b0;
        e2d_rd_write = 1'b0;
        finish_test();
    endtask

    task automatic test_commands();
        pipe_cmd_e cmds[2] = '{CMD_KILL, CMD_BRANCH};
        logic      r1;
        logic      r2;
        start_test("kill and branch");
        foreach (cmds[i]) begin
            // Park a word in the output register first
            send(random_regs(FUNCT7_BASE, FUNCT3_AND, OPC_OP), 32'h400, r1, r2);
            e2d_ready       = 1'b0;
            f2d_valid       = 1'b1;
            f2d.instr       = random_regs(FUNCT7_BASE, FUNCT3_OR, OPC_OP);
            e2d_cmd         = cmds[i];
            e2d_jump_target = next_random();
            #1;
            check("d2f_cmd", cmds[i], d2f_cmd);
            check("d2f_jump_target", e2d_jump_target, d2f_jump_target);
            @(posedge clk);
            #2;
            check("d2e_valid after command", 1'b0, d2e_valid);
            // Output slot is empty now, only the command holds fetch off
            check("d2f_ready under command", 1'b0, d2f_ready);
            e2d_cmd   = CMD_NONE;
            f2d_valid = 1'b0;
            e2d_ready = 1'b1;
        end
        finish_test();
    endtask

    initial begin
        clk             = 1'b0;
        arst_n          = 1'b0;
        f2d_valid       = 1'b0;
        f2d             = '0;
        e2d_ready       = 1'b1;
        e2d_cmd         = CMD_NONE;
        e2d_jump_target = '0;
        e2d_rd_write    = 1'b0;
        e2d_rd_waddr    = '0;
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        test_alu();
        test_muldiv();
        test_other();
        test_backpressure();
        test_hazard();
        test_commands();
        $display("%0d tests run, %0d failed, %0d failed checks, %0d assertion failures",
                 tests_run, tests_failed, total_errors, dut_i.props_i.fail_count);
        if (tests_failed == 0 && dut_i.props_i.fail_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
riscv_isa_pkg.sv
decode_pipe_pkg.sv
decode_classify.sv
decode_hazard.sv
decode_stage_reg.sv
decode_top.sv
decode_props.sv
tb_decode_top.sv

// ==== Bender.yml ====
package:
  name: decode_stage

export_include_dirs:
  - .

sources:
  - riscv_isa_pkg.sv
  - decode_pipe_pkg.sv
  - decode_classify.sv
  - decode_hazard.sv
  - decode_stage_reg.sv
  - decode_top.sv
  - target: test
    files:
      - decode_props.sv
      - tb_decode_top.sv
